/* hw/ifetch_pkg.sv */
package ifetch_pkg;

	// fetch timing
	localparam int unsigned IMEM_TIMEOUT_TH = 16; // cycles a transfer may wait for a response
	localparam int unsigned TMO_CW = $clog2(IMEM_TIMEOUT_TH); // timeout counter width
	localparam logic [31:0] RESET_PC = 32'h0000_0000;

	// ITCM geometry
	localparam int unsigned ITCM_WORDS = 256;
	localparam int unsigned ITCM_AW = 8; // word index width

	// memory map
	localparam logic [31:0] ITCM_BASE = 32'h0000_0000; // window of ITCM_WORDS*4 bytes
	localparam logic [31:0] EXT_BASE = 32'h8000_0000; // everything above goes to the ext port
	// the gap between the ITCM window and EXT_BASE is a decode hole

	// response error codes seen by the fetch stage
	typedef enum logic [1:0]
	{
		ERR_NONE = 2'd0,
		ERR_UNALIGNED = 2'd1,
		ERR_BUS = 2'd2,
		ERR_TIMEOUT = 2'd3
	} imem_err_e;

	// router destinations
	typedef enum logic [1:0]
	{
		TGT_ITCM = 2'd0,
		TGT_EXT = 2'd1,
		TGT_DECERR = 2'd2
	} bus_tgt_e;

endpackage

/* hw/fetch_pc_gen.sv */
`timescale 1ns/10ps

module fetch_pc_gen
	import ifetch_pkg::*;
(
	input logic clk,
	input logic resetn,
	input logic fetch_en,
	input logic redirect,
	input logic [31:0] redirect_pc,
	output logic [31:0] req_addr,
	output logic req_valid,
	input logic req_ready,
	input logic resp_valid,
	output logic [31:0] resp_pc
);

	logic [31:0] pc;
	logic req_fire;

	// pc of every issued request, popped by each response
	logic [31:0] pc_fifo [2];
	logic pc_wptr;
	logic pc_rptr;

	assign req_valid = fetch_en; // never looks at ready
	assign req_addr = pc;
	assign req_fire = req_valid & req_ready;

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
			pc <= RESET_PC;
		else if (redirect)
			pc <= redirect_pc; // an accept in this cycle still used the old pc
		else if (req_fire)
			pc <= pc + 32'd4;
	end

	always_ff @(posedge clk)
	begin
		if (req_fire)
			pc_fifo[pc_wptr] <= pc;
	end

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
		begin
			pc_wptr <= 1'b0;
			pc_rptr <= 1'b0;
		end
		else
		begin
			if (req_fire)
				pc_wptr <= ~pc_wptr;
			// the timeout response also consumes one entry
			if (resp_valid)
				pc_rptr <= ~pc_rptr;
		end
	end

	assign resp_pc = pc_fifo[pc_rptr];

endmodule

/* hw/ibus_ctrl.sv */
`timescale 1ns/10ps

module ibus_ctrl
	import ifetch_pkg::*;
(
	input logic clk,
	input logic resetn,

	// fetch request
	input logic [31:0] req_addr,
	input logic req_valid,
	output logic req_ready,

	// fetch response as a single-cycle strobe
	output logic [31:0] resp_rdata,
	output imem_err_e resp_err,
	output logic resp_valid,

	// read-only ICB master
	output logic [31:0] cmd_addr,
	output logic cmd_valid,
	input logic cmd_ready,
	input logic [31:0] rsp_rdata,
	input logic rsp_err,
	input logic rsp_valid,
	output logic rsp_ready,

	output logic ibus_timeout
);

	logic trans_start;
	logic trans_finish;
	logic clr_all;
	logic [1:0] out_cnt; // outstanding transfers 0..2
	logic no_outstanding;
	logic pc_aligned;

	// misalignment flag per outstanding transfer with one-hot pointers
	logic unal_flag [2];
	logic [1:0] fifo_wptr;
	logic [1:0] fifo_rptr;
	logic head_unaligned;

	logic [TMO_CW-1:0] tmo_cnt;
	logic tmo_flag; // sticky until reset
	logic tmo_pulse; // one cycle pulse that carries the ERR_TIMEOUT response
	logic tmo_expire;

	logic resp_ok;
	logic resp_unal;
	logic resp_bus_err;

	assign pc_aligned = (req_addr[1:0] == 2'b00);
	assign trans_start = req_valid & req_ready;
	assign trans_finish = resp_valid;
	assign no_outstanding = (out_cnt == 2'd0);
	assign clr_all = tmo_pulse;

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
			out_cnt <= 2'd0;
		else if (clr_all)
			out_cnt <= 2'd0;
		else if (trans_start & ~trans_finish)
			out_cnt <= out_cnt + 2'd1;
		else if (trans_finish & ~trans_start)
			out_cnt <= out_cnt - 2'd1;
	end

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
		begin
			fifo_wptr <= 2'b01;
			fifo_rptr <= 2'b01;
		end
		else
		begin
			if (trans_start)
				fifo_wptr <= {fifo_wptr[0], fifo_wptr[1]};
			if (trans_finish)
				fifo_rptr <= {fifo_rptr[0], fifo_rptr[1]};
		end
	end

	always_ff @(posedge clk)
	begin
		for (int i = 0; i < 2; i++)
		begin
			if (trans_start & fifo_wptr[i])
				unal_flag[i] <= ~pc_aligned;
		end
	end

	assign head_unaligned = (fifo_rptr[0] & unal_flag[0]) | (fifo_rptr[1] & unal_flag[1]);

	// aligned requests go straight through to the command channel
	assign cmd_addr = req_addr;
	assign cmd_valid = req_valid & pc_aligned & ~tmo_flag & ~out_cnt[1];
	assign req_ready = ~tmo_flag & ~out_cnt[1] & (~pc_aligned | cmd_ready);

	// restarts on every response and runs while anything is owed
	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
			tmo_cnt <= '0;
		else if (~tmo_flag & (~no_outstanding | trans_finish))
			tmo_cnt <= trans_finish ? '0 : tmo_cnt + 1'b1;
	end

	// a response in the last cycle still counts as in time
	assign tmo_expire = ~tmo_flag & ~no_outstanding & ~trans_finish
		& (tmo_cnt == TMO_CW'(IMEM_TIMEOUT_TH - 1));

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
		begin
			tmo_flag <= 1'b0;
			tmo_pulse <= 1'b0;
		end
		else
		begin
			if (tmo_expire)
				tmo_flag <= 1'b1;
			tmo_pulse <= tmo_expire;
		end
	end

	assign ibus_timeout = tmo_flag;

	// response channel
	// a misaligned head answers on its own and blocks the bus response behind it
	assign rsp_ready = ~tmo_flag & ~(~no_outstanding & head_unaligned);
	assign resp_ok = rsp_valid & rsp_ready & ~rsp_err;
	assign resp_bus_err = rsp_valid & rsp_ready & rsp_err;
	assign resp_unal = ~tmo_flag & ~no_outstanding & head_unaligned;

	assign resp_valid = resp_ok | resp_bus_err | resp_unal | tmo_pulse;
	assign resp_rdata = rsp_rdata;

	always_comb
	begin
		if (tmo_pulse)
			resp_err = ERR_TIMEOUT;
		else if (resp_unal)
			resp_err = ERR_UNALIGNED;
		else if (resp_bus_err)
			resp_err = ERR_BUS;
		else
			resp_err = ERR_NONE;
	end

endmodule

/* hw/icb_route.sv */
`timescale 1ns/10ps

module icb_route
	import ifetch_pkg::*;
(
	input logic clk,
	input logic resetn,

	// upstream slave
	input logic [31:0] cmd_addr,
	input logic cmd_valid,
	output logic cmd_ready,
	output logic [31:0] rsp_rdata,
	output logic rsp_err,
	output logic rsp_valid,
	input logic rsp_ready,

	// ITCM master
	output logic [ITCM_AW-1:0] itcm_cmd_addr,
	output logic itcm_cmd_valid,
	input logic itcm_cmd_ready,
	input logic [31:0] itcm_rsp_rdata,
	input logic itcm_rsp_valid,
	output logic itcm_rsp_ready,

	// external master
	output logic [31:0] ext_cmd_addr,
	output logic ext_cmd_valid,
	input logic ext_cmd_ready,
	input logic [31:0] ext_rsp_rdata,
	input logic ext_rsp_err,
	input logic ext_rsp_valid,
	output logic ext_rsp_ready
);

	bus_tgt_e cmd_tgt;
	logic [31:0] itcm_off;
	logic tgt_ready;
	logic cmd_fire;
	logic rsp_fire;

	// targets in issue order
	bus_tgt_e ord_fifo [2];
	logic ord_wptr;
	logic ord_rptr;
	logic [1:0] ord_cnt;
	logic ord_full;
	bus_tgt_e head_tgt;

	assign itcm_off = cmd_addr - ITCM_BASE; // wraps for addresses below the base

	always_comb
	begin
		if (itcm_off < 32'(ITCM_WORDS * 4))
			cmd_tgt = TGT_ITCM;
		else if (cmd_addr >= EXT_BASE)
			cmd_tgt = TGT_EXT;
		else
			cmd_tgt = TGT_DECERR;
	end

	assign ord_full = ord_cnt[1];
	assign itcm_cmd_addr = itcm_off[ITCM_AW+1:2];
	assign ext_cmd_addr = cmd_addr;
	assign itcm_cmd_valid = cmd_valid & ~ord_full & (cmd_tgt == TGT_ITCM);
	assign ext_cmd_valid = cmd_valid & ~ord_full & (cmd_tgt == TGT_EXT);

	// decode errors are always taken
	assign tgt_ready = (cmd_tgt == TGT_ITCM) ? itcm_cmd_ready :
		(cmd_tgt == TGT_EXT) ? ext_cmd_ready : 1'b1;
	assign cmd_ready = ~ord_full & tgt_ready;
	assign cmd_fire = cmd_valid & cmd_ready;

	always_ff @(posedge clk)
	begin
		if (cmd_fire)
			ord_fifo[ord_wptr] <= cmd_tgt;
	end

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
		begin
			ord_wptr <= 1'b0;
			ord_rptr <= 1'b0;
			ord_cnt <= 2'd0;
		end
		else
		begin
			if (cmd_fire)
				ord_wptr <= ~ord_wptr;
			if (rsp_fire)
				ord_rptr <= ~ord_rptr;
			ord_cnt <= ord_cnt + {1'b0, cmd_fire} - {1'b0, rsp_fire};
		end
	end

	assign head_tgt = ord_fifo[ord_rptr];

	// only the head target may answer, a decerr head answers at once
	always_comb
	begin
		rsp_valid = 1'b0;
		rsp_rdata = 32'd0;
		rsp_err = 1'b0;
		if (ord_cnt != 2'd0)
		begin
			case (head_tgt)
				TGT_ITCM:
				begin
					rsp_valid = itcm_rsp_valid;
					rsp_rdata = itcm_rsp_rdata;
				end
				TGT_EXT:
				begin
					rsp_valid = ext_rsp_valid;
					rsp_rdata = ext_rsp_rdata;
					rsp_err = ext_rsp_err;
				end
				default:
				begin
					rsp_valid = 1'b1;
					rsp_err = 1'b1;
				end
			endcase
		end
	end

	assign rsp_fire = rsp_valid & rsp_ready;
	assign itcm_rsp_ready = (ord_cnt != 2'd0) & (head_tgt == TGT_ITCM) & rsp_ready;
	assign ext_rsp_ready = (ord_cnt != 2'd0) & (head_tgt == TGT_EXT) & rsp_ready;

endmodule

/* hw/itcm.sv */
`timescale 1ns/10ps

module itcm
	import ifetch_pkg::*;
(
	input logic clk,
	input logic resetn,

	// load port, one write per strobe
	input logic load_valid,
	input logic [ITCM_AW-1:0] load_addr,
	input logic [31:0] load_data,

	// ICB slave, reads only
	input logic [ITCM_AW-1:0] cmd_addr,
	input logic cmd_valid,
	output logic cmd_ready,
	output logic [31:0] rsp_rdata,
	output logic rsp_valid,
	input logic rsp_ready
);

	logic [31:0] mem [ITCM_WORDS];
	logic [31:0] rdata_q;
	logic rvalid_q;
	logic cmd_fire;

	// a new read may start when the pending response leaves this cycle
	assign cmd_ready = ~rvalid_q | rsp_ready;
	assign cmd_fire = cmd_valid & cmd_ready;

	always_ff @(posedge clk)
	begin
		if (load_valid)
			mem[load_addr] <= load_data;
	end

	always_ff @(posedge clk)
	begin
		if (cmd_fire)
			rdata_q <= mem[cmd_addr]; // one cycle read latency
	end

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
			rvalid_q <= 1'b0;
		else if (cmd_fire)
			rvalid_q <= 1'b1;
		else if (rsp_ready)
			rvalid_q <= 1'b0; // response taken
	end

	assign rsp_valid = rvalid_q;
	assign rsp_rdata = rdata_q;

endmodule

/* hw/ifetch_top.sv */
`timescale 1ns/10ps

module ifetch_top
	import ifetch_pkg::*;
(
	input logic clk,
	input logic resetn,
	input logic fetch_en,
	input logic redirect,
	input logic [31:0] redirect_pc,
	input logic load_valid,
	input logic [ITCM_AW-1:0] load_addr,
	input logic [31:0] load_data,
	output logic resp_valid,
	output logic [31:0] resp_pc,
	output logic [31:0] resp_rdata,
	output imem_err_e resp_err,
	output logic [31:0] ext_cmd_addr,
	output logic ext_cmd_valid,
	input logic ext_cmd_ready,
	input logic [31:0] ext_rsp_rdata,
	input logic ext_rsp_err,
	input logic ext_rsp_valid,
	output logic ext_rsp_ready,
	output logic ibus_timeout
);

	// fetch request
	logic [31:0] req_addr;
	logic req_valid;
	logic req_ready;

	// controller to router
	logic [31:0] cmd_addr;
	logic cmd_valid;
	logic cmd_ready;
	logic [31:0] rsp_rdata;
	logic rsp_err;
	logic rsp_valid;
	logic rsp_ready;

	// router to ITCM
	logic [ITCM_AW-1:0] itcm_cmd_addr;
	logic itcm_cmd_valid;
	logic itcm_cmd_ready;
	logic [31:0] itcm_rsp_rdata;
	logic itcm_rsp_valid;
	logic itcm_rsp_ready;

	fetch_pc_gen i_fetch_pc_gen
	(
		.clk(clk),
		.resetn(resetn),
		.fetch_en(fetch_en),
		.redirect(redirect),
		.redirect_pc(redirect_pc),
		.req_addr(req_addr),
		.req_valid(req_valid),
		.req_ready(req_ready),
		.resp_valid(resp_valid),
		.resp_pc(resp_pc)
	);

	ibus_ctrl i_ibus_ctrl
	(
		.clk(clk),
		.resetn(resetn),
		.req_addr(req_addr),
		.req_valid(req_valid),
		.req_ready(req_ready),
		.resp_rdata(resp_rdata),
		.resp_err(resp_err),
		.resp_valid(resp_valid),
		.cmd_addr(cmd_addr),
		.cmd_valid(cmd_valid),
		.cmd_ready(cmd_ready),
		.rsp_rdata(rsp_rdata),
		.rsp_err(rsp_err),
		.rsp_valid(rsp_valid),
		.rsp_ready(rsp_ready),
		.ibus_timeout(ibus_timeout)
	);

	icb_route i_icb_route
	(
		.clk(clk),
		.resetn(resetn),
		.cmd_addr(cmd_addr),
		.cmd_valid(cmd_valid),
		.cmd_ready(cmd_ready),
		.rsp_rdata(rsp_rdata),
		.rsp_err(rsp_err),
		.rsp_valid(rsp_valid),
		.rsp_ready(rsp_ready),
		.itcm_cmd_addr(itcm_cmd_addr),
		.itcm_cmd_valid(itcm_cmd_valid),
		.itcm_cmd_ready(itcm_cmd_ready),
		.itcm_rsp_rdata(itcm_rsp_rdata),
		.itcm_rsp_valid(itcm_rsp_valid),
		.itcm_rsp_ready(itcm_rsp_ready),
		.ext_cmd_addr(ext_cmd_addr),
		.ext_cmd_valid(ext_cmd_valid),
		.ext_cmd_ready(ext_cmd_ready),
		.ext_rsp_rdata(ext_rsp_rdata),
		.ext_rsp_err(ext_rsp_err),
		.ext_rsp_valid(ext_rsp_valid),
		.ext_rsp_ready(ext_rsp_ready)
	);

	itcm i_itcm
	(
		.clk(clk),
		.resetn(resetn),
		.load_valid(load_valid),
		.load_addr(load_addr),
		.load_data(load_data),
		.cmd_addr(itcm_cmd_addr),
		.cmd_valid(itcm_cmd_valid),
		.cmd_ready(itcm_cmd_ready),
		.rsp_rdata(itcm_rsp_rdata),
		.rsp_valid(itcm_rsp_valid),
		.rsp_ready(itcm_rsp_ready)
	);

endmodule

/* tests/ifetch_model.svh */
`ifndef IFETCH_MODEL_SVH
`define IFETCH_MODEL_SVH

// mirror of the ITCM, follows every load strobe
logic [31:0] mirror [ITCM_WORDS];

// expected responses, oldest first
logic [31:0] exp_pc_q [$];
logic [31:0] exp_data_q [$];
imem_err_e exp_err_q [$];

logic [31:0] model_pc; // pc of the next request

// memory map lookup for an aligned address
function automatic bus_tgt_e addr_target(input logic [31:0] addr);
	if ((addr - ITCM_BASE) < 32'(ITCM_WORDS * 4))
		return TGT_ITCM;
	if (addr >= EXT_BASE)
		return TGT_EXT;
	return TGT_DECERR; // hole between the ITCM window and the ext window
endfunction

// what an accepted fetch at pc has to return
task automatic expect_fetch(input logic [31:0] pc, input logic [31:0] ext_data,
	input logic ext_err);
	logic [31:0] off;
	off = pc - ITCM_BASE;
	exp_pc_q.push_back(pc);
	if (pc[1:0] != 2'b00)
	begin
		exp_data_q.push_back(32'd0); // never sent on the bus
		exp_err_q.push_back(ERR_UNALIGNED);
	end
	else
	begin
		case (addr_target(pc))
			TGT_ITCM:
			begin
				exp_data_q.push_back(mirror[off[ITCM_AW+1:2]]);
				exp_err_q.push_back(ERR_NONE);
			end
			TGT_EXT:
			begin
				exp_data_q.push_back(ext_data);
				exp_err_q.push_back(ext_err ? ERR_BUS : ERR_NONE);
			end
			default:
			begin
				exp_data_q.push_back(32'd0);
				exp_err_q.push_back(ERR_BUS);
			end
		endcase
	end
endtask

task automatic drop_expected();
	void'(exp_pc_q.pop_front());
	void'(exp_data_q.pop_front());
	void'(exp_err_q.pop_front());
endtask

`endif

/* tests/ifetch_tb.sv */
`timescale 1ns/10ps

module ifetch_tb
	import ifetch_pkg::*;
();

	localparam int CYCLE_LIMIT = 6000; // about 2000 cycles of tests plus margin

	logic clk;
	logic resetn;
	logic fetch_en;
	logic redirect;
	logic [31:0] redirect_pc;
	logic load_valid;
	logic [ITCM_AW-1:0] load_addr;
	logic [31:0] load_data;
	logic resp_valid;
	logic [31:0] resp_pc;
	logic [31:0] resp_rdata;
	imem_err_e resp_err;
	logic [31:0] ext_cmd_addr;
	logic ext_cmd_valid;
	logic ext_cmd_ready;
	logic [31:0] ext_rsp_rdata;
	logic ext_rsp_err;
	logic ext_rsp_valid;
	logic ext_rsp_ready;
	logic ibus_timeout;

	integer seed;
	int cyc;
	int err_cnt;
	int resp_cnt;
	int acc_cnt;
	int bad_tests;

	// external slave, one entry per accepted command
	logic [31:0] slv_data_q [$];
	logic slv_err_q [$];
	int slv_wait;
	logic slv_hold; // withhold all responses

	logic tmo_mode; // next response must be the timeout
	logic frozen; // timeout seen, everything stays quiet
	int tmo_seen;
	int first_acc_cyc;

	`include "ifetch_model.svh"

	ifetch_top i_ifetch_top
	(
		.clk(clk),
		.resetn(resetn),
		.fetch_en(fetch_en),
		.redirect(redirect),
		.redirect_pc(redirect_pc),
		.load_valid(load_valid),
		.load_addr(load_addr),
		.load_data(load_data),
		.resp_valid(resp_valid),
		.resp_pc(resp_pc),
		.resp_rdata(resp_rdata),
		.resp_err(resp_err),
		.ext_cmd_addr(ext_cmd_addr),
		.ext_cmd_valid(ext_cmd_valid),
		.ext_cmd_ready(ext_cmd_ready),
		.ext_rsp_rdata(ext_rsp_rdata),
		.ext_rsp_err(ext_rsp_err),
		.ext_rsp_valid(ext_rsp_valid),
		.ext_rsp_ready(ext_rsp_ready),
		.ibus_timeout(ibus_timeout)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#5 clk = ~clk;
	end

	initial
	begin
		cyc = 0;
		while (cyc < CYCLE_LIMIT)
		begin
			@(posedge clk);
			cyc++;
		end
		$display("run stopped after %0d cycles without finishing the tests", CYCLE_LIMIT);
		$display("Test failed");
		$finish;
	end

	task automatic report_value(input string name, input logic [31:0] got,
		input logic [31:0] want);
		$display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, want);
		err_cnt++;
	endtask

	task automatic report_fault(input string what);
		$display("at %0t ns: %s", $time, what);
		err_cnt++;
	endtask

	function automatic logic [31:0] pick_target(input logic with_ext);
		logic [31:0] r;
		logic [1:0] kind;
		logic [31:0] word;
		r = $random(seed);
		kind = r[31:30];
		word = ITCM_BASE + {22'd0, r[9:2], 2'b00};
		if (with_ext)
			return kind[1] ? EXT_BASE + {16'd0, r[15:2], 2'b00} : word;
		if (kind == 2'd2)
			return ITCM_BASE + 32'(ITCM_WORDS * 4) + {4'd0, r[27:2], 2'b00}; // hole
		if (kind == 2'd3)
			return word | {30'd0, (r[1:0] == 2'b00) ? 2'b10 : r[1:0]};
		return word;
	endfunction

	task automatic drive_slave();
		ext_cmd_ready = (($random(seed) & 3) != 0); // ready 3 cycles in 4
		ext_rsp_valid = 1'b0;
		ext_rsp_rdata = 32'd0;
		ext_rsp_err = 1'b0;
		if (slv_data_q.size() != 0 && !slv_hold)
		begin
			if (slv_wait == 0)
			begin
				ext_rsp_valid = 1'b1;
				ext_rsp_rdata = slv_data_q[0];
				ext_rsp_err = slv_err_q[0];
			end
			else
				slv_wait--;
		end
	endtask

	task automatic check_resp();
		resp_cnt++;
		if (exp_pc_q.size() == 0)
			report_fault("response arrived with no request outstanding");
		else if (tmo_mode)
		begin
			if (resp_err != ERR_TIMEOUT)
				report_value("resp_err", 32'(resp_err), 32'(ERR_TIMEOUT));
			if (resp_pc != exp_pc_q[0])
				report_value("resp_pc", resp_pc, exp_pc_q[0]);
			if (cyc - first_acc_cyc > int'(IMEM_TIMEOUT_TH) + 2)
				report_fault("timeout response came too late");
			tmo_seen++;
			exp_pc_q.delete(); // outstanding transfers are dropped
			exp_data_q.delete();
			exp_err_q.delete();
			slv_data_q.delete();
			slv_err_q.delete();
			tmo_mode = 1'b0;
			frozen = 1'b1;
		end
		else
		begin
			if (resp_pc != exp_pc_q[0])
				report_value("resp_pc", resp_pc, exp_pc_q[0]);
			if (resp_err != exp_err_q[0])
				report_value("resp_err", 32'(resp_err), 32'(exp_err_q[0]));
			else if (resp_err == ERR_NONE && resp_rdata != exp_data_q[0])
				report_value("resp_rdata", resp_rdata, exp_data_q[0]);
			drop_expected();
		end
	endtask

	// everything here is settled, the next rising edge commits it
	task automatic sample();
		logic acc;
		logic [31:0] xdata;
		logic xerr;
		acc = i_ifetch_top.req_valid & i_ifetch_top.req_ready;
		xdata = 32'd0;
		xerr = 1'b0;
		if (load_valid)
			mirror[load_addr] = load_data;
		if (ext_cmd_valid && (ext_cmd_addr[1:0] != 2'b00 || addr_target(ext_cmd_addr) != TGT_EXT))
			report_fault("external command for an address outside the external window");
		if (ext_cmd_valid && exp_pc_q.size() >= 2)
			report_fault("external command while two responses are still owed");
		if (frozen && (resp_valid || ext_cmd_valid || acc || !ibus_timeout))
			report_fault("fetch path active after the bus timeout");
		if (resp_valid)
			check_resp();
		if (ext_rsp_valid && ext_rsp_ready)
		begin
			void'(slv_data_q.pop_front());
			void'(slv_err_q.pop_front());
			slv_wait = $random(seed) & 3;
		end
		if (acc)
		begin
			acc_cnt++;
			if (model_pc[1:0] == 2'b00 && addr_target(model_pc) == TGT_EXT)
			begin
				if (!(ext_cmd_valid && ext_cmd_ready) || ext_cmd_addr != model_pc)
					report_fault("external fetch accepted without its bus command");
				xdata = $random(seed);
				xerr = (($random(seed) & 7) == 0);
				slv_data_q.push_back(xdata);
				slv_err_q.push_back(xerr);
			end
			if (tmo_mode && first_acc_cyc < 0)
				first_acc_cyc = cyc;
			expect_fetch(model_pc, xdata, xerr);
		end
		if (redirect)
			model_pc = redirect_pc; // an accept in this cycle used the old pc
		else if (acc)
			model_pc = model_pc + 32'd4;
	endtask

	// inputs were set at this falling edge
	task automatic tick();
		drive_slave();
		#2;
		sample();
		@(negedge clk);
		redirect = 1'b0;
		load_valid = 1'b0;
	endtask

	task automatic drain();
		fetch_en = 1'b0;
		while (exp_pc_q.size() != 0)
			tick();
	endtask

	task automatic end_test(input string name, input int errs_before);
		if (err_cnt == errs_before)
			$display("%s: ok", name);
		else
		begin
			$display("%s: %0d errors", name, err_cnt - errs_before);
			bad_tests++;
		end
	endtask

	initial
	begin
		int e0;
		int n;
		seed = 32'h1202_8fbf;
		resetn = 1'b0;
		fetch_en = 1'b0;
		redirect = 1'b0;
		redirect_pc = 32'd0;
		load_valid = 1'b0;
		load_addr = '0;
		load_data = 32'd0;
		ext_cmd_ready = 1'b0;
		ext_rsp_rdata = 32'd0;
		ext_rsp_err = 1'b0;
		ext_rsp_valid = 1'b0;
		err_cnt = 0;
		resp_cnt = 0;
		acc_cnt = 0;
		bad_tests = 0;
		slv_wait = 0;
		slv_hold = 1'b0;
		tmo_mode = 1'b0;
		frozen = 1'b0;
		tmo_seen = 0;
		first_acc_cyc = -1;
		model_pc = RESET_PC;
		repeat (5) @(posedge clk);
		@(negedge clk);
		resetn = 1'b1;

		e0 = err_cnt;
		repeat (8)
		begin
			tick();
			if (resp_valid || ibus_timeout || ext_cmd_valid || ext_rsp_ready)
				report_fault("an output is high after reset before fetching starts");
		end
		end_test("test 1 reset state", e0);

		e0 = err_cnt;
		for (int i = 0; i < int'(ITCM_WORDS); i++)
		begin
			load_valid = 1'b1;
			load_addr = ITCM_AW'(i);
			load_data = $random(seed);
			tick();
		end
		n = acc_cnt;
		fetch_en = 1'b1;
		while (acc_cnt - n < int'(ITCM_WORDS))
			tick();
		drain();
		end_test("test 2 ITCM streaming", e0);

		e0 = err_cnt;
		repeat (400)
		begin
			fetch_en = (($random(seed) & 7) != 0);
			if (($random(seed) & 7) == 0)
			begin
				redirect = 1'b1;
				redirect_pc = pick_target(1'b0); // ITCM, hole or misaligned
			end
			tick();
		end
		drain();
		end_test("test 3 random redirects", e0);

		e0 = err_cnt;
		redirect = 1'b1;
		redirect_pc = EXT_BASE;
		repeat (600)
		begin
			fetch_en = (($random(seed) & 7) != 0);
			if (($random(seed) % 6) == 0)
			begin
				redirect = 1'b1;
				redirect_pc = pick_target(1'b1);
			end
			tick();
		end
		drain();
		end_test("test 4 external and ITCM mix", e0);

		e0 = err_cnt;
		slv_hold = 1'b1;
		redirect = 1'b1;
		redirect_pc = EXT_BASE + 32'h100;
		tick();
		tmo_mode = 1'b1;
		fetch_en = 1'b1;
		n = 0;
		while (tmo_seen == 0 && n < 100)
		begin
			tick();
			n++;
		end
		if (tmo_seen == 0)
			report_fault("no timeout response while the external slave stayed silent");
		repeat (50)
			tick(); // frozen checks run in every cycle
		end_test("test 5 bus timeout", e0);

		$display("%0d responses, %0d errors, %0d of 5 tests with errors",
			resp_cnt, err_cnt, bad_tests);
		if (err_cnt == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

/* ifetch.f */
+incdir+tests
hw/ifetch_pkg.sv
hw/fetch_pc_gen.sv
hw/ibus_ctrl.sv
hw/icb_route.sv
hw/itcm.sv
hw/ifetch_top.sv
tests/ifetch_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the ifetch testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module ifetch_tb -f ifetch.f \
	&& ./obj_dir/Vifetch_tb | tee /dev/stderr | grep -x "Test passed" > /dev/null \
	&& echo "simulation ok" \
	|| { echo "simulation not ok"; exit 1; }
